/* hw/lsq_pkg.sv */
`default_nettype none

package lsq_pkg;

    // address and data paths
    localparam int addr_w = 32;
    localparam int data_w = 32;

    // operation field and codes
    localparam int op_w = 3;
    localparam logic [op_w-1:0] op_none  = 3'd0;
    localparam logic [op_w-1:0] op_load  = 3'd1;
    localparam logic [op_w-1:0] op_store = 3'd2;

    // access size, 0 = byte, 1 = half, 2 = word
    localparam int size_w = 2;
    localparam logic [size_w-1:0] size_byte = 2'd0;
    localparam logic [size_w-1:0] size_half = 2'd1;

    // miss register index and per-bank metadata layout
    localparam int mshr_idx_w   = 3;
    localparam int bank_meta_w  = 1 + mshr_idx_w;
    localparam int meta_rdy_bit = 0;
    localparam int meta_idx_lsb = 1;

    // line address drops the byte offset and the bank select bit
    localparam int line_w = addr_w - 3;

    // entry metadata, odd bank in the high nibble
    typedef union packed {
        logic [2*bank_meta_w-1:0]      raw;
        logic [1:0][bank_meta_w-1:0]   banks;
    } lsq_meta_u;

endpackage

`default_nettype wire

/* hw/qnm.sv */
`timescale 1ns/1ns
`default_nettype none

module qnm #(
    parameter int n_width  = 8,
    parameter int m_width  = 8,
    parameter int q_length = 8
) (
    input  wire                         clk,
    input  wire                         arst_n,
    input  wire                         wr,
    input  wire                         rd,
    input  wire  [n_width-1:0]          n_din,
    input  wire  [m_width-1:0]          m_din,
    input  wire  [q_length-1:0]         modify_vector,
    input  wire  [m_width*q_length-1:0] new_m_vector,
    output logic [n_width+m_width-1:0]  dout,
    output logic [m_width*q_length-1:0] old_m_vector,
    output logic                        full,
    output logic                        empty
);

    localparam int ptr_w = (q_length > 1) ? $clog2(q_length) : 1;
    localparam int cnt_w = $clog2(q_length + 1);

    // payload fixed at push, metadata rewritable per slot
    logic [n_width-1:0] payload_mem [q_length];
    logic [m_width-1:0] meta_mem [q_length];

    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             do_push;
    logic             do_pop;

    // wrap at q_length, which need not be a power of two
    function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
        if (p == ptr_w'(q_length - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    assign full  = (count == cnt_w'(q_length));
    assign empty = (count == '0);

    // push while full and pop while empty are dropped
    assign do_push = wr && !full;
    assign do_pop  = rd && !empty;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            // simultaneous push and pop leaves the count alone
            case ({do_push, do_pop})
                2'b10:   count <= count + cnt_w'(1);
                2'b01:   count <= count - cnt_w'(1);
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            payload_mem[wr_ptr] <= n_din;
        end
    end

    for (genvar i = 0; i < q_length; i++) begin : g_meta
        // push wins, the slot being written is empty anyway
        always_ff @(posedge clk) begin
            if (do_push && wr_ptr == ptr_w'(i)) begin
                meta_mem[i] <= m_din;
            end else if (modify_vector[i]) begin
                meta_mem[i] <= new_m_vector[i*m_width +: m_width];
            end
        end

        // flat export of every slot
        assign old_m_vector[i*m_width +: m_width] = meta_mem[i];
    end

    // head slot, payload above metadata
    assign dout = {payload_mem[rd_ptr], meta_mem[rd_ptr]};

endmodule

`default_nettype wire

/* hw/cache_bank.sv */
`timescale 1ns/1ns
`default_nettype none

module cache_bank import lsq_pkg::*; #(
    parameter int fill_latency = 6,
    parameter int bank_lines   = 16
) (
    input  wire                    clk,
    input  wire                    arst_n,
    input  wire                    lookup,
    input  wire  [line_w-1:0]      line_addr,
    output logic                   hit,
    output logic [mshr_idx_w-1:0]  mshr_wr_idx,
    output logic                   fin,
    output logic [mshr_idx_w-1:0]  fin_idx
);

    localparam int idx_w  = $clog2(bank_lines);
    localparam int ctag_w = line_w - idx_w;
    localparam int n_mshr = 1 << mshr_idx_w;
    localparam int cnt_w  = $clog2(fill_latency + 1);

    // direct-mapped tag store
    logic [ctag_w-1:0]     tag_mem [bank_lines];
    logic [bank_lines-1:0] line_valid;

    // miss registers
    logic [n_mshr-1:0] mshr_busy;
    logic [line_w-1:0] mshr_line [n_mshr];
    logic [cnt_w-1:0]  mshr_cnt [n_mshr];
    logic [n_mshr-1:0] mshr_done;

    logic [idx_w-1:0]  look_idx;
    logic [ctag_w-1:0] look_tag;
    logic [idx_w-1:0]  fill_idx;
    logic              miss;
    logic              have_free;

    assign look_idx = line_addr[idx_w-1:0];
    assign look_tag = line_addr[line_w-1:idx_w];

    // hit decided on registered tags only
    assign hit  = lookup && line_valid[look_idx] && (tag_mem[look_idx] == look_tag);
    assign miss = lookup && !hit;

    // lowest free register takes the next miss
    always_comb begin
        mshr_wr_idx = '0;
        have_free   = 1'b0;
        for (int i = n_mshr - 1; i >= 0; i--) begin
            if (!mshr_busy[i]) begin
                mshr_wr_idx = mshr_idx_w'(i);
                have_free   = 1'b1;
            end
        end
    end

    // one fin per cycle, lowest expired index first
    always_comb begin
        fin     = 1'b0;
        fin_idx = '0;
        for (int i = n_mshr - 1; i >= 0; i--) begin
            mshr_done[i] = mshr_busy[i] && (mshr_cnt[i] == '0);
            if (mshr_done[i]) begin
                fin     = 1'b1;
                fin_idx = mshr_idx_w'(i);
            end
        end
    end

    assign fill_idx = mshr_line[fin_idx][idx_w-1:0];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mshr_busy  <= '0;
            line_valid <= '0;
            for (int i = 0; i < n_mshr; i++) begin
                mshr_cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < n_mshr; i++) begin
                if (fin && fin_idx == mshr_idx_w'(i)) begin
                    mshr_busy[i] <= 1'b0;
                end else if (miss && have_free && mshr_wr_idx == mshr_idx_w'(i)) begin
                    // fin shows up fill_latency cycles after this edge
                    mshr_busy[i] <= 1'b1;
                    mshr_cnt[i]  <= cnt_w'(fill_latency);
                end else if (mshr_busy[i] && mshr_cnt[i] != '0) begin
                    mshr_cnt[i] <= mshr_cnt[i] - cnt_w'(1);
                end
            end
            if (fin) begin
                line_valid[fill_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (miss && have_free) begin
            mshr_line[mshr_wr_idx] <= line_addr;
        end
        // fill replaces whatever line held the slot
        if (fin) begin
            tag_mem[fill_idx] <= mshr_line[fin_idx][line_w-1:idx_w];
        end
    end

endmodule

`default_nettype wire

/* hw/lsq.sv */
`timescale 1ns/1ns
`default_nettype none

module lsq import lsq_pkg::*; #(
    parameter int q_length = 8,
    parameter int tag_bits = 6,
    parameter int rob_bits = 6
) (
    input  wire                   clk,
    input  wire                   arst_n,
    input  wire                   alloc,
    input  wire                   dealloc,
    input  wire  [op_w-1:0]       operation_in,
    input  wire  [addr_w-1:0]     addr_in,
    input  wire  [data_w-1:0]     data_in,
    input  wire  [size_w-1:0]     size_in,
    input  wire  [tag_bits-1:0]   ooo_tag_in,
    input  wire  [rob_bits-1:0]   ooo_rob_in,
    input  wire                   hit_even,
    input  wire                   hit_odd,
    input  wire  [mshr_idx_w-1:0] mshr_wr_idx_even,
    input  wire  [mshr_idx_w-1:0] mshr_wr_idx_odd,
    input  wire                   mshr_fin_even,
    input  wire  [mshr_idx_w-1:0] mshr_fin_idx_even,
    input  wire                   mshr_fin_odd,
    input  wire  [mshr_idx_w-1:0] mshr_fin_idx_odd,
    output logic [op_w-1:0]       operation_out,
    output logic [addr_w-1:0]     addr_out,
    output logic [data_w-1:0]     data_out,
    output logic [size_w-1:0]     size_out,
    output logic [tag_bits-1:0]   ooo_tag_out,
    output logic [rob_bits-1:0]   ooo_rob_out,
    output logic                  valid_out,
    output logic                  lsq_full
);

    localparam int n_w = op_w + addr_w + data_w + size_w + tag_bits + rob_bits;
    localparam int m_w = $bits(lsq_meta_u);

    lsq_meta_u                    meta_in;
    lsq_meta_u                    head_meta;
    logic [n_w+m_w-1:0]           q_dout;
    logic [n_w-1:0]               head_payload;
    logic [m_w*q_length-1:0]      old_m_vector;
    logic [m_w*q_length-1:0]      new_m_vector;
    logic [q_length-1:0]          modify_vector;
    logic                         q_empty;

    // bank 0 is even, bank 1 is odd, same order as the union
    logic [1:0]                   bank_hit;
    logic [1:0]                   bank_fin;
    logic [1:0][mshr_idx_w-1:0]   bank_wr_idx;
    logic [1:0][mshr_idx_w-1:0]   bank_fin_idx;

    assign bank_hit     = {hit_odd, hit_even};
    assign bank_fin     = {mshr_fin_odd, mshr_fin_even};
    assign bank_wr_idx  = {mshr_wr_idx_odd, mshr_wr_idx_even};
    assign bank_fin_idx = {mshr_fin_idx_odd, mshr_fin_idx_even};

    // new entry metadata
    // a fill landing on the claimed index this cycle counts as ready
    always_comb begin
        for (int b = 0; b < 2; b++) begin
            meta_in.banks[b][meta_rdy_bit] = bank_hit[b] ||
                (bank_fin[b] && bank_fin_idx[b] == bank_wr_idx[b]);
            meta_in.banks[b][bank_meta_w-1:meta_idx_lsb] = bank_wr_idx[b];
        end
    end

    qnm #(
        .n_width  (n_w),
        .m_width  (m_w),
        .q_length (q_length)
    ) u_qnm (
        .clk           (clk),
        .arst_n        (arst_n),
        .wr            (alloc),
        .rd            (dealloc),
        .n_din         ({operation_in, addr_in, data_in, size_in, ooo_tag_in, ooo_rob_in}),
        .m_din         (meta_in.raw),
        .modify_vector (modify_vector),
        .new_m_vector  (new_m_vector),
        .dout          (q_dout),
        .old_m_vector  (old_m_vector),
        .full          (lsq_full),
        .empty         (q_empty)
    );

    // per-slot fill matching
    for (genvar i = 0; i < q_length; i++) begin : g_slot
        lsq_meta_u  cur_meta;
        lsq_meta_u  nxt_meta;
        logic [1:0] fin_match;

        always_comb begin
            cur_meta.raw = old_m_vector[i*m_w +: m_w];
            nxt_meta     = cur_meta;
            for (int b = 0; b < 2; b++) begin
                // only a waiting half looks at the fin
                fin_match[b] = !cur_meta.banks[b][meta_rdy_bit] && bank_fin[b] &&
                    (cur_meta.banks[b][bank_meta_w-1:meta_idx_lsb] == bank_fin_idx[b]);
                if (fin_match[b]) begin
                    nxt_meta.banks[b][meta_rdy_bit] = 1'b1;
                end
            end
        end

        assign modify_vector[i]             = |fin_match;
        assign new_m_vector[i*m_w +: m_w]   = nxt_meta.raw;
    end

    // head split into payload fields and metadata
    assign head_payload = q_dout[n_w+m_w-1:m_w];
    assign head_meta    = q_dout[m_w-1:0];

    assign {operation_out, addr_out, data_out, size_out, ooo_tag_out, ooo_rob_out} =
        head_payload;

    // head shown once both halves are ready
    assign valid_out = !q_empty && head_meta.banks[0][meta_rdy_bit] &&
        head_meta.banks[1][meta_rdy_bit];

endmodule

`default_nettype wire

/* hw/lsq_subsystem.sv */
`timescale 1ns/1ns
`default_nettype none

module lsq_subsystem import lsq_pkg::*; #(
    parameter int q_length     = 8,
    parameter int tag_bits     = 6,
    parameter int rob_bits     = 6,
    parameter int fill_latency = 6,
    parameter int bank_lines   = 16
) (
    input  wire                  clk,
    input  wire                  arst_n,
    input  wire                  alloc,
    input  wire  [op_w-1:0]      operation_in,
    input  wire  [addr_w-1:0]    addr_in,
    input  wire  [data_w-1:0]    data_in,
    input  wire  [size_w-1:0]    size_in,
    input  wire  [tag_bits-1:0]  ooo_tag_in,
    input  wire  [rob_bits-1:0]  ooo_rob_in,
    input  wire                  dealloc,
    output logic                 valid_out,
    output logic                 lsq_full,
    output logic [op_w-1:0]      operation_out,
    output logic [addr_w-1:0]    addr_out,
    output logic [data_w-1:0]    data_out,
    output logic [size_w-1:0]    size_out,
    output logic [tag_bits-1:0]  ooo_tag_out,
    output logic [rob_bits-1:0]  ooo_rob_out
);

    logic [2:0]            byte_cnt;
    logic [2:0]            last_off;
    logic                  first_odd;
    logic                  split;
    logic                  touch_even;
    logic                  touch_odd;
    logic                  do_lookup;
    logic [line_w-1:0]     line_even;
    logic [line_w-1:0]     line_odd;
    logic                  bank_hit_even;
    logic                  bank_hit_odd;
    logic [mshr_idx_w-1:0] wr_idx_even;
    logic [mshr_idx_w-1:0] wr_idx_odd;
    logic                  fin_even;
    logic                  fin_odd;
    logic [mshr_idx_w-1:0] fin_idx_even;
    logic [mshr_idx_w-1:0] fin_idx_odd;

    // bytes covered by the access, unknown sizes act as a word
    always_comb begin
        case (size_in)
            size_byte: byte_cnt = 3'd1;
            size_half: byte_cnt = 3'd2;
            default:   byte_cnt = 3'd4;
        endcase
    end

    // crossing the word boundary pulls in the other bank
    assign last_off   = {1'b0, addr_in[1:0]} + byte_cnt - 3'd1;
    assign split      = (last_off > 3'd3);
    assign first_odd  = addr_in[2];
    assign touch_even = !first_odd || split;
    assign touch_odd  = first_odd || split;

    // odd first means the even half lives in the next line
    assign line_odd  = addr_in[addr_w-1:3];
    assign line_even = first_odd ? addr_in[addr_w-1:3] + 1'b1 : addr_in[addr_w-1:3];

    // lookup only for accesses the queue really takes
    assign do_lookup = alloc && !lsq_full;

    cache_bank #(
        .fill_latency (fill_latency),
        .bank_lines   (bank_lines)
    ) u_bank_even (
        .clk         (clk),
        .arst_n      (arst_n),
        .lookup      (do_lookup && touch_even),
        .line_addr   (line_even),
        .hit         (bank_hit_even),
        .mshr_wr_idx (wr_idx_even),
        .fin         (fin_even),
        .fin_idx     (fin_idx_even)
    );

    cache_bank #(
        .fill_latency (fill_latency),
        .bank_lines   (bank_lines)
    ) u_bank_odd (
        .clk         (clk),
        .arst_n      (arst_n),
        .lookup      (do_lookup && touch_odd),
        .line_addr   (line_odd),
        .hit         (bank_hit_odd),
        .mshr_wr_idx (wr_idx_odd),
        .fin         (fin_odd),
        .fin_idx     (fin_idx_odd)
    );

    // untouched half is handed over as a hit
    lsq #(
        .q_length (q_length),
        .tag_bits (tag_bits),
        .rob_bits (rob_bits)
    ) u_lsq (
        .clk               (clk),
        .arst_n            (arst_n),
        .alloc             (alloc),
        .dealloc           (dealloc),
        .operation_in      (operation_in),
        .addr_in           (addr_in),
        .data_in           (data_in),
        .size_in           (size_in),
        .ooo_tag_in        (ooo_tag_in),
        .ooo_rob_in        (ooo_rob_in),
        .hit_even          (bank_hit_even || !touch_even),
        .hit_odd           (bank_hit_odd || !touch_odd),
        .mshr_wr_idx_even  (wr_idx_even),
        .mshr_wr_idx_odd   (wr_idx_odd),
        .mshr_fin_even     (fin_even),
        .mshr_fin_idx_even (fin_idx_even),
        .mshr_fin_odd      (fin_odd),
        .mshr_fin_idx_odd  (fin_idx_odd),
        .operation_out     (operation_out),
        .addr_out          (addr_out),
        .data_out          (data_out),
        .size_out          (size_out),
        .ooo_tag_out       (ooo_tag_out),
        .ooo_rob_out       (ooo_rob_out),
        .valid_out         (valid_out),
        .lsq_full          (lsq_full)
    );

endmodule

`default_nettype wire

/* dv/lsq_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module lsq_tb import lsq_pkg::*; ();

    localparam int q_length      = 8;
    localparam int tag_bits      = 6;
    localparam int rob_bits      = 6;
    localparam int fill_latency  = 6;
    localparam int bank_lines    = 16;
    localparam int valid_timeout = 4 * fill_latency + 20;
    localparam int pl_w = op_w + addr_w + data_w + size_w + tag_bits + rob_bits;

    // stimulus table with one access per row
    // per row the address, size (0 byte, 1 half, 2 word), operation,
    // idle cycles before dealloc and chain (1 = push next row before draining)
    localparam int n_rows = 14;
    localparam logic [addr_w-1:0] tbl_addr [n_rows] = '{
        32'h0000_0100, 32'h0000_0104, 32'h0000_0101, 32'h0000_0106, 32'h0000_0106,
        32'h0000_020e, 32'h0000_021f, 32'h0000_0207, 32'h0000_0900, 32'h0000_0100,
        32'h0000_0300, 32'h0000_0204, 32'h0000_0220, 32'h0000_090c};
    localparam logic [size_w-1:0] tbl_size [n_rows] = '{
        2'd2, 2'd2, 2'd0, 2'd2, 2'd2, 2'd1, 2'd2, 2'd1, 2'd2, 2'd2, 2'd2, 2'd0, 2'd2, 2'd2};
    localparam logic [op_w-1:0] tbl_op [n_rows] = '{
        op_load, op_store, op_load, op_load, op_store, op_load, op_store,
        op_load, op_load, op_store, op_load, op_store, op_load, op_load};
    localparam int tbl_idle [n_rows] = '{0, 1, 0, 2, 0, 0, 3, 0, 0, 1, 0, 0, 2, 0};
    localparam bit tbl_chain [n_rows] = '{
        1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0,
        1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1, 1'b0};

    logic                clk;
    logic                arst_n;
    logic                alloc;
    logic [op_w-1:0]     operation_in;
    logic [addr_w-1:0]   addr_in;
    logic [data_w-1:0]   data_in;
    logic [size_w-1:0]   size_in;
    logic [tag_bits-1:0] ooo_tag_in;
    logic [rob_bits-1:0] ooo_rob_in;
    logic                dealloc;
    logic                valid_out;
    logic                lsq_full;
    logic [op_w-1:0]     operation_out;
    logic [addr_w-1:0]   addr_out;
    logic [data_w-1:0]   data_out;
    logic [size_w-1:0]   size_out;
    logic [tag_bits-1:0] ooo_tag_out;
    logic [rob_bits-1:0] ooo_rob_out;

    // pushed payloads in issue order
    logic [pl_w-1:0] ref_q [$];

    // reference tags with bank 0 even and bank 1 odd
    logic [line_w-1:0] ref_line [2][bank_lines];
    bit                ref_valid [2][bank_lines];

    int check_count;
    int error_count;
    int timeout_count;

    lsq_subsystem #(
        .q_length     (q_length),
        .tag_bits     (tag_bits),
        .rob_bits     (rob_bits),
        .fill_latency (fill_latency),
        .bank_lines   (bank_lines)
    ) i_lsq_subsystem (
        .clk           (clk),
        .arst_n        (arst_n),
        .alloc         (alloc),
        .operation_in  (operation_in),
        .addr_in       (addr_in),
        .data_in       (data_in),
        .size_in       (size_in),
        .ooo_tag_in    (ooo_tag_in),
        .ooo_rob_in    (ooo_rob_in),
        .dealloc       (dealloc),
        .valid_out     (valid_out),
        .lsq_full      (lsq_full),
        .operation_out (operation_out),
        .addr_out      (addr_out),
        .data_out      (data_out),
        .size_out      (size_out),
        .ooo_tag_out   (ooo_tag_out),
        .ooo_rob_out   (ooo_rob_out)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        assert (got === exp) else begin
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
            error_count++;
        end
    endtask

    // one word of the access against the reference tags
    // the line counts as filled from here on
    task automatic probe_model(input logic [addr_w-1:0] word_addr, inout bit all_hit);
        int                bank;
        int                idx;
        logic [line_w-1:0] line;
        bank = int'(word_addr[2]);
        line = word_addr[addr_w-1:3];
        idx  = int'(32'(line) % 32'(bank_lines));
        if (!(ref_valid[bank][idx] && ref_line[bank][idx] == line)) begin
            all_hit = 1'b0;
        end
        ref_valid[bank][idx] = 1'b1;
        ref_line[bank][idx]  = line;
    endtask

    // split when the last byte runs past the word
    task automatic lookup_model(input logic [addr_w-1:0] addr, input logic [size_w-1:0] size,
                                output bit all_hit);
        int                nbytes;
        bit                split;
        logic [addr_w-1:0] word_addr;
        nbytes    = (size == 2'd0) ? 1 : (size == 2'd1) ? 2 : 4;
        split     = (int'(addr[1:0]) + nbytes - 1) > 3;
        word_addr = {addr[addr_w-1:2], 2'b00};
        all_hit   = 1'b1;
        probe_model(word_addr, all_hit);
        if (split) begin
            probe_model(word_addr + 32'd4, all_hit);
        end
    endtask

    // returns at the edge that samples alloc
    task automatic push_entry(input logic [addr_w-1:0] addr, input logic [size_w-1:0] size,
                              input logic [op_w-1:0] op, input bit record,
                              output bit all_hit);
        int unsigned         rnd;
        logic [data_w-1:0]   data;
        logic [tag_bits-1:0] tag;
        logic [rob_bits-1:0] rob;
        rnd     = $urandom;
        data    = rnd;
        rnd     = $urandom;
        tag     = rnd[tag_bits-1:0];
        rob     = rnd[tag_bits+rob_bits-1:tag_bits];
        all_hit = 1'b1;
        if (record) begin
            lookup_model(addr, size, all_hit);
            ref_q.push_back({op, addr, data, size, tag, rob});
        end
        @(posedge clk);
        alloc        <= 1'b1;
        operation_in <= op;
        addr_in      <= addr;
        data_in      <= data;
        size_in      <= size;
        ooo_tag_in   <= tag;
        ooo_rob_in   <= rob;
        @(posedge clk);
        alloc <= 1'b0;
    endtask

    // valid_out sampled on falling edges while cycles counts rising edges since the call
    task automatic wait_valid(output int cycles, output bit seen);
        cycles = 0;
        @(negedge clk);
        seen = valid_out;
        while (!seen && cycles < valid_timeout) begin
            @(negedge clk);
            cycles++;
            seen = valid_out;
        end
        if (!seen) begin
            $display("timeout: valid_out stayed low for %0d cycles with %0d entries queued",
                     cycles, ref_q.size());
            timeout_count++;
        end
    endtask

    // pop everything in order and check latency on the first head only
    task automatic drain_queue(input bit check_lat, input bit exp_hit, input int idle);
        int                  lat;
        bit                  seen;
        bit                  first;
        logic [op_w-1:0]     e_op;
        logic [addr_w-1:0]   e_addr;
        logic [data_w-1:0]   e_data;
        logic [size_w-1:0]   e_size;
        logic [tag_bits-1:0] e_tag;
        logic [rob_bits-1:0] e_rob;
        first = check_lat;
        while (ref_q.size() > 0) begin
            wait_valid(lat, seen);
            if (first && seen) begin
                check_count++;
                if (exp_hit) begin
                    assert (lat <= 2) else begin
                        $display("hit at the head took %0d cycles to become valid", lat);
                        error_count++;
                    end
                end else begin
                    assert (lat == fill_latency + 1) else begin
                        $display("miss at the head became valid after %0d cycles, not %0d",
                                 lat, fill_latency + 1);
                        error_count++;
                    end
                end
            end
            first = 1'b0;
            if (seen) begin
                {e_op, e_addr, e_data, e_size, e_tag, e_rob} = ref_q[0];
                check_value("operation_out", 32'(operation_out), 32'(e_op));
                check_value("addr_out", addr_out, e_addr);
                check_value("data_out", data_out, e_data);
                check_value("size_out", 32'(size_out), 32'(e_size));
                check_value("ooo_tag_out", 32'(ooo_tag_out), 32'(e_tag));
                check_value("ooo_rob_out", 32'(ooo_rob_out), 32'(e_rob));
                repeat (idle) @(posedge clk);
                @(posedge clk);
                dealloc <= 1'b1;
                @(posedge clk);
                dealloc <= 1'b0;
            end
            ref_q.delete(0);
        end
        // nothing left behind
        @(negedge clk);
        check_value("valid_out", 32'(valid_out), 32'd0);
    endtask

    // fill with hits and no dealloc before one push too many
    task automatic overfill_queue();
        bit all_hit;
        for (int k = 1; k <= q_length; k++) begin
            push_entry(32'h0000_0220, 2'd2, op_load, 1'b1, all_hit);
            @(negedge clk);
            check_value("lsq_full", 32'(lsq_full), (k == q_length) ? 32'd1 : 32'd0);
        end
        // a miss if taken that must leave no trace
        push_entry(32'h0000_0a00, 2'd2, op_store, 1'b0, all_hit);
        @(negedge clk);
        check_value("lsq_full", 32'(lsq_full), 32'd1);
        drain_queue(1'b0, 1'b1, 0);
        check_value("lsq_full", 32'(lsq_full), 32'd0);
    endtask

    initial begin
        int unsigned seed;
        int          group_len;
        bit          all_hit;
        seed = 32'h4c34_629b;
        void'($urandom(seed));
        check_count   = 0;
        error_count   = 0;
        timeout_count = 0;
        arst_n       = 1'b0;
        alloc        = 1'b0;
        operation_in = op_none;
        addr_in      = '0;
        data_in      = '0;
        size_in      = '0;
        ooo_tag_in   = '0;
        ooo_rob_in   = '0;
        dealloc      = 1'b0;
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        check_value("valid_out", 32'(valid_out), 32'd0);
        check_value("lsq_full", 32'(lsq_full), 32'd0);

        // single rows drain alone while chained rows pile up behind a miss
        group_len = 0;
        for (int i = 0; i < n_rows; i++) begin
            push_entry(tbl_addr[i], tbl_size[i], tbl_op[i], 1'b1, all_hit);
            group_len++;
            if (!tbl_chain[i]) begin
                drain_queue(group_len == 1, all_hit, tbl_idle[i]);
                group_len = 0;
            end
        end

        overfill_queue();

        $display("checks: %0d  errors: %0d  timeouts: %0d",
                 check_count, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
hw/lsq_pkg.sv
hw/qnm.sv
hw/cache_bank.sv
hw/lsq.sv
hw/lsq_subsystem.sv
dv/lsq_tb.sv

/* Makefile */
# Verilator flow for the load/store queue testbench
# override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= lsq_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Simulation finished: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "sim passed"; \
	else \
		echo "sim failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
